// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_ecc_line
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) hdl/*.sv testbench/*.sv testbench/*.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a nonzero exit status
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/ecc_59_cal.sv ====
`timescale 1ns/1ns
`default_nettype none

module ecc_59_cal
    import ecc_pkg::*;
(
    input  wire  [ECC_DATA_W-1:0] data_in,
    input  wire  [ECC_PAR_W-1:0]  parity_in,
    input  wire                   bypass,
    output logic [ECC_DATA_W-1:0] data_out,
    output logic [ECC_DATA_W-1:0] mask,
    output logic                  sbit_err,
    output logic                  dbit_err
);

    logic [ECC_PAR_W-1:0]  syndrome;
    logic [ECC_DATA_W-1:0] match;
    logic                  data_hit;
    logic                  check_hit;
    logic                  nonzero;

    assign syndrome = parity_in ^ ecc_parity(data_in);

    // Columns are all distinct, so at most one match
    always_comb begin
        for (int i = 0; i < ECC_DATA_W; i++) begin
            match[i] = (syndrome == ECC_COLUMNS[i]);
        end
    end

    assign nonzero  = |syndrome;
    assign data_hit = |match;

    // One syndrome bit set means the flipped bit was a check bit
    assign check_hit = nonzero && ((syndrome & (syndrome - 1'b1)) == '0);

    assign mask     = bypass ? '0 : match;
    assign data_out = data_in ^ mask;

    assign sbit_err = !bypass && (data_hit || check_hit);
    assign dbit_err = !bypass && nonzero && !data_hit && !check_hit;

endmodule

`default_nettype wire

// ==== hdl/ecc_line_merge.sv ====
`timescale 1ns/1ns
`default_nettype none

module ecc_line_merge
    import ecc_pkg::*;
(
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire                      rd_valid,
    input  wire  [ECC_ADDR_W-1:0]    rd_addr_q,
    input  wire  [ECC_DATA_W-1:0]    data0,
    input  wire  [ECC_DATA_W-1:0]    data1,
    input  wire  [ECC_DATA_W-1:0]    mask0,
    input  wire  [ECC_DATA_W-1:0]    mask1,
    input  wire                      sbe0,
    input  wire                      dbe0,
    input  wire                      sbe1,
    input  wire                      dbe1,
    output logic                     rsp_valid,
    output logic [2*ECC_DATA_W-1:0]  rsp_data,
    output logic                     rsp_sbe,
    output logic                     rsp_dbe,
    output logic [ECC_CNT_W-1:0]     sbe_count,
    output logic [ECC_CNT_W-1:0]     dbe_count,
    output logic                     last_err_lane,
    output logic [ECC_BIT_W-1:0]     last_err_bit,
    output logic [ECC_ADDR_W-1:0]    last_err_addr
);

    logic                  line_sbe;
    logic                  line_dbe;
    logic                  err_seen;
    logic                  err_lane;
    logic [ECC_DATA_W-1:0] err_mask;
    logic [ECC_BIT_W-1:0]  err_bit;

    // A double error anywhere hides single errors on the line
    assign line_dbe = dbe0 | dbe1;
    assign line_sbe = (sbe0 | sbe1) & ~line_dbe;

    assign err_seen = (|mask0) | (|mask1);
    assign err_lane = ~(|mask0);
    assign err_mask = err_lane ? mask1 : mask0;

    always_comb begin
        err_bit = '0;
        for (int i = 0; i < ECC_DATA_W; i++) begin
            if (err_mask[i]) begin
                err_bit = i[ECC_BIT_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid) begin
            rsp_data <= {data1, data0};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid     <= 1'b0;
            rsp_sbe       <= 1'b0;
            rsp_dbe       <= 1'b0;
            sbe_count     <= '0;
            dbe_count     <= '0;
            last_err_lane <= 1'b0;
            last_err_bit  <= '0;
            last_err_addr <= '0;
        end else begin
            rsp_valid <= rd_valid;
            rsp_sbe   <= rd_valid & line_sbe;
            rsp_dbe   <= rd_valid & line_dbe;
            // Counters stick at all ones
            if (rd_valid && line_sbe && sbe_count != '1) begin
                sbe_count <= sbe_count + 1'b1;
            end
            if (rd_valid && line_dbe && dbe_count != '1) begin
                dbe_count <= dbe_count + 1'b1;
            end
            if (rd_valid && err_seen) begin
                last_err_lane <= err_lane;
                last_err_bit  <= err_bit;
                last_err_addr <= rd_addr_q;
            end
        end
    end

    a_mask_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        rd_valid |-> ($onehot0(mask0) && $onehot0(mask1)));

    a_flags_excl: assert property (@(posedge clk) disable iff (!arst_n)
        rd_valid |-> (!(sbe0 && dbe0) && !(sbe1 && dbe1)));

endmodule

`default_nettype wire

// ==== hdl/ecc_line_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module ecc_line_store
    import ecc_pkg::*;
(
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire                      wr_en,
    input  wire  [ECC_ADDR_W-1:0]    wr_addr,
    input  wire  [2*ECC_DATA_W-1:0]  wr_data,
    input  wire  [ECC_WORD_W-1:0]    wr_flip0,
    input  wire  [ECC_WORD_W-1:0]    wr_flip1,
    input  wire                      rd_en,
    input  wire  [ECC_ADDR_W-1:0]    rd_addr,
    output ecc_lane_u                rd_word0,
    output ecc_lane_u                rd_word1,
    output logic                     rd_valid,
    output logic [ECC_ADDR_W-1:0]    rd_addr_q
);

    ecc_lane_u              mem [ECC_DEPTH][2];
    ecc_lane_u              clean [2];
    ecc_lane_u              faulted [2];
    logic [ECC_WORD_W-1:0]  flip [2];

    assign flip[0] = wr_flip0;
    assign flip[1] = wr_flip1;

    // Lane 0 sits in the low half of the line
    always_comb begin
        for (int l = 0; l < 2; l++) begin
            clean[l].word.data   = wr_data[l*ECC_DATA_W +: ECC_DATA_W];
            clean[l].word.parity = ecc_parity(wr_data[l*ECC_DATA_W +: ECC_DATA_W]);
            faulted[l].raw       = clean[l].raw ^ flip[l];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr][0] <= faulted[0];
            mem[wr_addr][1] <= faulted[1];
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_word0  <= mem[rd_addr][0];
            rd_word1  <= mem[rd_addr][1];
            rd_addr_q <= rd_addr;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    a_wr_addr_known: assert property (@(posedge clk) disable iff (!arst_n)
        wr_en |-> !$isunknown(wr_addr));

    a_rd_addr_known: assert property (@(posedge clk) disable iff (!arst_n)
        rd_en |-> !$isunknown(rd_addr));

endmodule

`default_nettype wire

// ==== hdl/ecc_line_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module ecc_line_top
    import ecc_pkg::*;
(
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire                      wr_en,
    input  wire  [ECC_ADDR_W-1:0]    wr_addr,
    input  wire  [2*ECC_DATA_W-1:0]  wr_data,
    input  wire  [ECC_WORD_W-1:0]    wr_flip0,
    input  wire  [ECC_WORD_W-1:0]    wr_flip1,
    input  wire                      rd_en,
    input  wire  [ECC_ADDR_W-1:0]    rd_addr,
    input  wire                      bypass,
    output logic                     rsp_valid,
    output logic [2*ECC_DATA_W-1:0]  rsp_data,
    output logic                     rsp_sbe,
    output logic                     rsp_dbe,
    output logic [ECC_CNT_W-1:0]     sbe_count,
    output logic [ECC_CNT_W-1:0]     dbe_count,
    output logic                     last_err_lane,
    output logic [ECC_BIT_W-1:0]     last_err_bit,
    output logic [ECC_ADDR_W-1:0]    last_err_addr
);

    ecc_lane_u              rd_word0;
    ecc_lane_u              rd_word1;
    logic                   rd_valid;
    logic [ECC_ADDR_W-1:0]  rd_addr_q;
    logic [ECC_DATA_W-1:0]  data0;
    logic [ECC_DATA_W-1:0]  data1;
    logic [ECC_DATA_W-1:0]  mask0;
    logic [ECC_DATA_W-1:0]  mask1;
    logic                   sbe0;
    logic                   dbe0;
    logic                   sbe1;
    logic                   dbe1;

    ecc_line_store line_store (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_flip0  (wr_flip0),
        .wr_flip1  (wr_flip1),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_word0  (rd_word0),
        .rd_word1  (rd_word1),
        .rd_valid  (rd_valid),
        .rd_addr_q (rd_addr_q)
    );

    ecc_59_cal lane0_chk (
        .data_in   (rd_word0.word.data),
        .parity_in (rd_word0.word.parity),
        .bypass    (bypass),
        .data_out  (data0),
        .mask      (mask0),
        .sbit_err  (sbe0),
        .dbit_err  (dbe0)
    );

    ecc_59_cal lane1_chk (
        .data_in   (rd_word1.word.data),
        .parity_in (rd_word1.word.parity),
        .bypass    (bypass),
        .data_out  (data1),
        .mask      (mask1),
        .sbit_err  (sbe1),
        .dbit_err  (dbe1)
    );

    ecc_line_merge line_merge (
        .clk           (clk),
        .arst_n        (arst_n),
        .rd_valid      (rd_valid),
        .rd_addr_q     (rd_addr_q),
        .data0         (data0),
        .data1         (data1),
        .mask0         (mask0),
        .mask1         (mask1),
        .sbe0          (sbe0),
        .dbe0          (dbe0),
        .sbe1          (sbe1),
        .dbe1          (dbe1),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .rsp_sbe       (rsp_sbe),
        .rsp_dbe       (rsp_dbe),
        .sbe_count     (sbe_count),
        .dbe_count     (dbe_count),
        .last_err_lane (last_err_lane),
        .last_err_bit  (last_err_bit),
        .last_err_addr (last_err_addr)
    );

endmodule

`default_nettype wire

// ==== hdl/ecc_pkg.sv ====
`default_nettype none

package ecc_pkg;

    localparam int ECC_DATA_W = 59;
    localparam int ECC_PAR_W  = 8;
    localparam int ECC_WORD_W = ECC_DATA_W + ECC_PAR_W;
    localparam int ECC_DEPTH  = 16;
    localparam int ECC_ADDR_W = 4;
    localparam int ECC_CNT_W  = 8;
    localparam int ECC_BIT_W  = $clog2(ECC_DATA_W);

    // Entry i lists the check bits that cover data bit i
    localparam logic [ECC_PAR_W-1:0] ECC_COLUMNS [ECC_DATA_W] = '{
        8'h83, 8'h85, 8'h86, 8'h07, 8'h89, 8'h8A, 8'h0B, 8'h8C, 8'h0D, 8'h0E,
        8'h8F, 8'h91, 8'h92, 8'h13, 8'h94, 8'h15, 8'h16, 8'h97, 8'h98, 8'h19,
        8'h1A, 8'h9B, 8'h1C, 8'h9D, 8'h9E, 8'h1F, 8'hA1, 8'hA2, 8'h23, 8'hA4,
        8'h25, 8'h26, 8'hA7, 8'hA8, 8'h29, 8'h2A, 8'hAB, 8'h2C, 8'hAD, 8'hAE,
        8'h2F, 8'hB0, 8'h31, 8'h32, 8'hB3, 8'h34, 8'hB5, 8'hB6, 8'h37, 8'h38,
        8'hB9, 8'hBA, 8'h3B, 8'hBC, 8'h3D, 8'h3E, 8'hBF, 8'hC1, 8'hC2
    };

    typedef struct packed {
        logic [ECC_PAR_W-1:0]  parity;
        logic [ECC_DATA_W-1:0] data;
    } ecc_lane_word_t;

    // Raw view is for bit-position fault injection
    typedef union packed {
        logic [ECC_WORD_W-1:0] raw;
        ecc_lane_word_t        word;
    } ecc_lane_u;

    function automatic logic [ECC_PAR_W-1:0] ecc_parity(input logic [ECC_DATA_W-1:0] data);
        logic [ECC_PAR_W-1:0] par;
        par = '0;
        for (int i = 0; i < ECC_DATA_W; i++) begin
            if (data[i]) begin
                par = par ^ ECC_COLUMNS[i];
            end
        end
        return par;
    endfunction

endpackage

`default_nettype wire

// ==== tb.f ====
+incdir+testbench
hdl/ecc_pkg.sv
hdl/ecc_59_cal.sv
hdl/ecc_line_store.sv
hdl/ecc_line_merge.sv
hdl/ecc_line_top.sv
testbench/tb_ecc_line.sv

// ==== testbench/tb_ecc_line_cases.svh ====
// Each entry holds a name, the operation, address, data, flip patterns and bypass,
// then the expected data and flags and, where one is checked, the error log
task automatic build_cases();
    logic [127:0]            rnd;
    logic [2*ECC_DATA_W-1:0] d [ECC_DEPTH];
    logic [ECC_WORD_W-1:0]   f0;
    logic [ECC_WORD_W-1:0]   f1;
    logic [2*ECC_DATA_W-1:0] raw7;
    for (int a = 0; a < ECC_DEPTH; a++) begin
        rnd  = {$random(seed), $random(seed), $random(seed), $random(seed)};
        d[a] = rnd[2*ECC_DATA_W-1:0];
    end
    for (int a = 0; a < 4; a++) begin
        write_entry("clean_wr", 4'(a), d[a], '0, '0);
    end
    for (int a = 0; a < 4; a++) begin
        read_entry("clean_rd", 4'(a), 1'b0, d[a], 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
    end
    write_entry("sbe_lane0", 4'd4, d[4], 67'd1 << 17, '0);
    read_entry("sbe_lane0", 4'd4, 1'b0, d[4], 1'b1, 1'b0, 1'b1, 1'b0, 6'd17, 4'd4);
    write_entry("sbe_lane1", 4'd5, d[5], '0, 67'd1 << 58);
    read_entry("sbe_lane1", 4'd5, 1'b0, d[5], 1'b1, 1'b0, 1'b1, 1'b1, 6'd58, 4'd5);
    // Raw bit 63 is check bit 4, so the log keeps the previous entry
    write_entry("sbe_check", 4'd6, d[6], 67'd1 << 63, '0);
    read_entry("sbe_check", 4'd6, 1'b0, d[6], 1'b1, 1'b0, 1'b1, 1'b1, 6'd58, 4'd5);
    f1   = (67'd1 << 3) | (67'd1 << 40);
    raw7 = d[7] ^ {f1[ECC_DATA_W-1:0], {ECC_DATA_W{1'b0}}};
    write_entry("dbe_lane1", 4'd7, d[7], '0, f1);
    read_entry("dbe_lane1", 4'd7, 1'b0, raw7, 1'b0, 1'b1, 1'b1, 1'b1, 6'd58, 4'd5);
    // Lane 0 still corrects and logs while lane 1 reports the double error
    f0 = 67'd1 << 5;
    f1 = (67'd1 << 10) | (67'd1 << 20);
    write_entry("sbe_and_dbe", 4'd8, d[8], f0, f1);
    read_entry("sbe_and_dbe", 4'd8, 1'b0, d[8] ^ {f1[ECC_DATA_W-1:0], {ECC_DATA_W{1'b0}}},
               1'b0, 1'b1, 1'b1, 1'b0, 6'd5, 4'd8);
    f0 = 67'd1 << 2;
    f1 = 67'd1 << 30;
    write_entry("bypass_sbe", 4'd9, d[9], f0, f1);
    read_entry("bypass_sbe", 4'd9, 1'b1, d[9] ^ {f1[ECC_DATA_W-1:0], f0[ECC_DATA_W-1:0]},
               1'b0, 1'b0, 1'b1, 1'b0, 6'd5, 4'd8);
    read_entry("bypass_dbe", 4'd7, 1'b1, raw7, 1'b0, 1'b0, 1'b1, 1'b0, 6'd5, 4'd8);
    read_entry("dbe_again", 4'd7, 1'b0, raw7, 1'b0, 1'b1, 1'b1, 1'b0, 6'd5, 4'd8);
    for (int k = 0; k < 260; k++) begin
        read_entry("sbe_saturate", 4'd4, 1'b0, d[4], 1'b1, 1'b0, 1'b1, 1'b0, 6'd17, 4'd4);
    end
endtask

// ==== testbench/tb_ecc_line.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_ecc_line
    import ecc_pkg::*;
();

    typedef struct packed {
        logic                    is_wr;
        logic [ECC_ADDR_W-1:0]   addr;
        logic [2*ECC_DATA_W-1:0] data;
        logic [ECC_WORD_W-1:0]   flip0;
        logic [ECC_WORD_W-1:0]   flip1;
        logic                    bypass;
        logic [2*ECC_DATA_W-1:0] exp_data;
        logic                    exp_sbe;
        logic                    exp_dbe;
        logic                    log_chk;
        logic                    exp_lane;
        logic [ECC_BIT_W-1:0]    exp_bit;
        logic [ECC_ADDR_W-1:0]   exp_addr;
    } tb_case_t;

    logic                    clk;
    logic                    arst_n;
    logic                    wr_en;
    logic [ECC_ADDR_W-1:0]   wr_addr;
    logic [2*ECC_DATA_W-1:0] wr_data;
    logic [ECC_WORD_W-1:0]   wr_flip0;
    logic [ECC_WORD_W-1:0]   wr_flip1;
    logic                    rd_en;
    logic [ECC_ADDR_W-1:0]   rd_addr;
    logic                    bypass;
    logic                    rsp_valid;
    logic [2*ECC_DATA_W-1:0] rsp_data;
    logic                    rsp_sbe;
    logic                    rsp_dbe;
    logic [ECC_CNT_W-1:0]    sbe_count;
    logic [ECC_CNT_W-1:0]    dbe_count;
    logic                    last_err_lane;
    logic [ECC_BIT_W-1:0]    last_err_bit;
    logic [ECC_ADDR_W-1:0]   last_err_addr;

    tb_case_t             cases [$];
    string                names [$];
    int                   seed = 32'h78766fa0;
    int                   cycles = 0;
    int                   limit = 0;
    logic [ECC_CNT_W-1:0] exp_sbe_cnt;
    logic [ECC_CNT_W-1:0] exp_dbe_cnt;

    ecc_line_top dut0 (
        .clk           (clk),
        .arst_n        (arst_n),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_flip0      (wr_flip0),
        .wr_flip1      (wr_flip1),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .bypass        (bypass),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .rsp_sbe       (rsp_sbe),
        .rsp_dbe       (rsp_dbe),
        .sbe_count     (sbe_count),
        .dbe_count     (dbe_count),
        .last_err_lane (last_err_lane),
        .last_err_bit  (last_err_bit),
        .last_err_addr (last_err_addr)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout: the test sequence did not finish within %0d cycles", limit);
        end
    end

    task automatic check_value(input string name, input string field,
            input logic [127:0] expected, input logic [127:0] actual);
        if (expected !== actual) begin
            $display("error %s %s: expected %0h, actual %0h", name, field, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch on %s", field);
        end
    endtask

    task automatic write_entry(input string name, input logic [ECC_ADDR_W-1:0] addr,
            input logic [2*ECC_DATA_W-1:0] data, input logic [ECC_WORD_W-1:0] f0,
            input logic [ECC_WORD_W-1:0] f1);
        tb_case_t c;
        c = '0;
        c.is_wr = 1'b1;
        c.addr  = addr;
        c.data  = data;
        c.flip0 = f0;
        c.flip1 = f1;
        cases.push_back(c);
        names.push_back(name);
    endtask

    task automatic read_entry(input string name, input logic [ECC_ADDR_W-1:0] addr,
            input logic byp, input logic [2*ECC_DATA_W-1:0] exp_data,
            input logic sbe, input logic dbe, input logic log_chk, input logic lane,
            input logic [ECC_BIT_W-1:0] bit_pos, input logic [ECC_ADDR_W-1:0] log_addr);
        tb_case_t c;
        c = '0;
        c.addr     = addr;
        c.bypass   = byp;
        c.exp_data = exp_data;
        c.exp_sbe  = sbe;
        c.exp_dbe  = dbe;
        c.log_chk  = log_chk;
        c.exp_lane = lane;
        c.exp_bit  = bit_pos;
        c.exp_addr = log_addr;
        cases.push_back(c);
        names.push_back(name);
    endtask

    `include "tb_ecc_line_cases.svh"

    task automatic apply_case(input int i);
        if (i < cases.size()) begin
            wr_en    = cases[i].is_wr;
            rd_en    = !cases[i].is_wr;
            wr_addr  = cases[i].addr;
            rd_addr  = cases[i].addr;
            wr_data  = cases[i].data;
            wr_flip0 = cases[i].flip0;
            wr_flip1 = cases[i].flip1;
        end else begin
            wr_en = 1'b0;
            rd_en = 1'b0;
        end
        // Check blocks see bypass in the cycle after the read strobe
        if (i >= 1 && i - 1 < cases.size() && !cases[i-1].is_wr) begin
            bypass = cases[i-1].bypass;
        end else begin
            bypass = 1'b0;
        end
    endtask

    task automatic check_response(input int j);
        tb_case_t c;
        c = cases[j];
        if (c.is_wr) begin
            check_value(names[j], "rsp_valid", 128'(1'b0), 128'(rsp_valid));
        end else begin
            check_value(names[j], "rsp_valid", 128'(1'b1), 128'(rsp_valid));
            check_value(names[j], "rsp_data", 128'(c.exp_data), 128'(rsp_data));
            check_value(names[j], "rsp_sbe", 128'(c.exp_sbe), 128'(rsp_sbe));
            check_value(names[j], "rsp_dbe", 128'(c.exp_dbe), 128'(rsp_dbe));
            // Counters saturate at all ones
            if (c.exp_sbe && exp_sbe_cnt != 8'hff) begin
                exp_sbe_cnt = exp_sbe_cnt + 8'd1;
            end
            if (c.exp_dbe && exp_dbe_cnt != 8'hff) begin
                exp_dbe_cnt = exp_dbe_cnt + 8'd1;
            end
            check_value(names[j], "sbe_count", 128'(exp_sbe_cnt), 128'(sbe_count));
            check_value(names[j], "dbe_count", 128'(exp_dbe_cnt), 128'(dbe_count));
            if (c.log_chk) begin
                check_value(names[j], "last_err_lane", 128'(c.exp_lane), 128'(last_err_lane));
                check_value(names[j], "last_err_bit", 128'(c.exp_bit), 128'(last_err_bit));
                check_value(names[j], "last_err_addr", 128'(c.exp_addr), 128'(last_err_addr));
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        wr_en       = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        wr_flip0    = '0;
        wr_flip1    = '0;
        rd_en       = 1'b0;
        rd_addr     = '0;
        bypass      = 1'b0;
        exp_sbe_cnt = '0;
        exp_dbe_cnt = '0;
        build_cases();
        limit = 4 * cases.size() + 40;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        // Every response is due exactly two cycles after its strobe
        for (int i = 0; i < cases.size() + 2; i++) begin
            @(negedge clk);
            if (i >= 2) begin
                check_response(i - 2);
            end
            apply_case(i);
        end
        check_value("sbe_saturate", "sbe_count", 128'(8'hff), 128'(sbe_count));
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire
